// ==== Bender.yml ====
package:
  name: pipeline_core

sources:
  - files:
      - logic/core_pkg.sv
      - logic/fetch_buffer.sv
      - logic/register_file.sv
      - logic/decode_stage.sv
      - logic/execute_stage.sv
      - logic/memory_stage.sv
      - logic/pipeline_core.sv
  - target: test
    files:
      - verif/pipeline_core_props.sv
      - verif/tb_pipeline_core.sv

// ==== logic/core_pkg.sv ====
package core_pkg;

  // Data and instruction widths
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      reg_addr_t;

  // ALU operation codes
  typedef logic [3:0] alu_op_t;

  localparam alu_op_t ALU_ADD = 4'd0;
  localparam alu_op_t ALU_SUB = 4'd1;
  localparam alu_op_t ALU_AND = 4'd2;
  localparam alu_op_t ALU_OR  = 4'd3;
  localparam alu_op_t ALU_XOR = 4'd4;
  localparam alu_op_t ALU_SLT = 4'd5;
  localparam alu_op_t ALU_SLL = 4'd6;
  localparam alu_op_t ALU_SRL = 4'd7;

  // RISC-V base opcodes still decoded
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // Fetch buffer entries, also the credits held by the sender after reset
  localparam int FETCH_DEPTH = 4;

  // Data memory size in words
  localparam int DMEM_WORDS = 64;

  // Word index, taken from address bits 7:2
  typedef logic [$clog2(DMEM_WORDS)-1:0] dmem_index_t;

endpackage

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic                i_clk,
  input  logic                i_reset,
  input  logic                i_inst_valid,
  input  core_pkg::inst_t     i_inst,
  input  logic                i_wb_we,
  input  core_pkg::reg_addr_t i_wb_rd,
  input  core_pkg::word_t     i_wb_data,
  output logic                o_stall,
  output logic                o_ex_valid,
  output logic                o_ex_we,
  output logic                o_ex_load,
  output logic                o_ex_store,
  output logic                o_ex_use_imm,
  output core_pkg::alu_op_t   o_ex_alu_op,
  output core_pkg::reg_addr_t o_ex_rd,
  output core_pkg::reg_addr_t o_ex_rs1_addr,
  output core_pkg::reg_addr_t o_ex_rs2_addr,
  output core_pkg::word_t     o_ex_rs1,
  output core_pkg::word_t     o_ex_rs2,
  output core_pkg::word_t     o_ex_imm
);

  import core_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  reg_addr_t  rd;
  reg_addr_t  rs1_addr;
  reg_addr_t  rs2_addr;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      imm;
  alu_op_t    funct_op;
  alu_op_t    alu_op;
  logic       funct_ok;
  logic       we;
  logic       is_load;
  logic       is_store;
  logic       use_imm;
  logic       uses_rs1;
  logic       uses_rs2;
  logic       load_use;
  logic       take;

  assign opcode   = i_inst[6:0];
  assign rd       = i_inst[11:7];
  assign funct3   = i_inst[14:12];
  assign rs1_addr = i_inst[19:15];
  assign rs2_addr = i_inst[24:20];

  register_file register_file_i (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_we       (i_wb_we),
    .i_waddr    (i_wb_rd),
    .i_wdata    (i_wb_data),
    .i_rs1_addr (rs1_addr),
    .i_rs2_addr (rs2_addr),
    .o_rs1      (rs1_data),
    .o_rs2      (rs2_data)
  );

  // ALU operation from funct3, sub only for register-register
  always_comb begin
    funct_op = ALU_ADD;
    funct_ok = 1'b1;
    case (funct3)
      3'b000:  funct_op = (opcode == OPC_OP && i_inst[30]) ? ALU_SUB : ALU_ADD;
      3'b001:  funct_op = ALU_SLL;
      3'b010:  funct_op = ALU_SLT;
      3'b100:  funct_op = ALU_XOR;
      3'b101:  funct_op = ALU_SRL;
      3'b110:  funct_op = ALU_OR;
      3'b111:  funct_op = ALU_AND;
      default: funct_ok = 1'b0;
    endcase
  end

  // Unknown encodings fall through as no-ops with we low
  always_comb begin
    we       = 1'b0;
    is_load  = 1'b0;
    is_store = 1'b0;
    use_imm  = 1'b0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    alu_op   = ALU_ADD;
    imm      = {{20{i_inst[31]}}, i_inst[31:20]};
    case (opcode)
      OPC_OP: begin
        we       = funct_ok;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        alu_op   = funct_op;
      end
      OPC_OP_IMM: begin
        we       = funct_ok;
        use_imm  = 1'b1;
        uses_rs1 = 1'b1;
        alu_op   = funct_op;
      end
      OPC_LOAD: begin
        we       = 1'b1;
        is_load  = 1'b1;
        use_imm  = 1'b1;
        uses_rs1 = 1'b1;
      end
      OPC_STORE: begin
        is_store = 1'b1;
        use_imm  = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        imm      = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
      end
      default: ;
    endcase
    if (rd == '0) begin
      we = 1'b0;
    end
  end

  // Load in execute whose result the head needs
  assign load_use = o_ex_valid && o_ex_load && o_ex_we &&
                    ((uses_rs1 && rs1_addr == o_ex_rd) ||
                     (uses_rs2 && rs2_addr == o_ex_rd));
  assign o_stall  = i_inst_valid && load_use;
  assign take     = i_inst_valid && !load_use;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_ex_valid <= 1'b0;
      o_ex_we    <= 1'b0;
      o_ex_load  <= 1'b0;
      o_ex_store <= 1'b0;
    end else begin
      // Bubble when nothing is taken
      o_ex_valid <= take;
      o_ex_we    <= take && we;
      o_ex_load  <= take && is_load;
      o_ex_store <= take && is_store;
    end
  end

  always_ff @(posedge i_clk) begin
    o_ex_use_imm  <= use_imm;
    o_ex_alu_op   <= alu_op;
    o_ex_rd       <= rd;
    o_ex_rs1_addr <= rs1_addr;
    o_ex_rs2_addr <= rs2_addr;
    o_ex_rs1      <= rs1_data;
    o_ex_rs2      <= rs2_data;
    o_ex_imm      <= imm;
  end

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
  input  logic                i_clk,
  input  logic                i_reset,
  input  logic                i_ex_valid,
  input  logic                i_ex_we,
  input  logic                i_ex_load,
  input  logic                i_ex_store,
  input  logic                i_ex_use_imm,
  input  core_pkg::alu_op_t   i_ex_alu_op,
  input  core_pkg::reg_addr_t i_ex_rd,
  input  core_pkg::reg_addr_t i_ex_rs1_addr,
  input  core_pkg::reg_addr_t i_ex_rs2_addr,
  input  core_pkg::word_t     i_ex_rs1,
  input  core_pkg::word_t     i_ex_rs2,
  input  core_pkg::word_t     i_ex_imm,
  input  logic                i_wb_valid,
  input  logic                i_wb_we,
  input  core_pkg::reg_addr_t i_wb_rd,
  input  core_pkg::word_t     i_wb_data,
  output logic                o_mem_valid,
  output logic                o_mem_we,
  output logic                o_mem_load,
  output logic                o_mem_store,
  output core_pkg::reg_addr_t o_mem_rd,
  output core_pkg::word_t     o_mem_result,
  output core_pkg::word_t     o_mem_store_data
);

  import core_pkg::*;

  word_t op_a;
  word_t rs2_fwd;
  word_t op_b;
  word_t alu_result;

  // Memory stage wins over writeback, loads in memory never forward
  function automatic word_t forward(input reg_addr_t addr, input word_t reg_value);
    word_t value;
    value = reg_value;
    if (o_mem_valid && o_mem_we && !o_mem_load && o_mem_rd == addr) begin
      value = o_mem_result;
    end else if (i_wb_valid && i_wb_we && i_wb_rd == addr) begin
      value = i_wb_data;
    end
    return value;
  endfunction

  always_comb begin
    op_a    = forward(i_ex_rs1_addr, i_ex_rs1);
    rs2_fwd = forward(i_ex_rs2_addr, i_ex_rs2);
    op_b    = i_ex_use_imm ? i_ex_imm : rs2_fwd;
  end

  // Also the effective address of loads and stores
  always_comb begin
    case (i_ex_alu_op)
      ALU_ADD: alu_result = op_a + op_b;
      ALU_SUB: alu_result = op_a - op_b;
      ALU_AND: alu_result = op_a & op_b;
      ALU_OR:  alu_result = op_a | op_b;
      ALU_XOR: alu_result = op_a ^ op_b;
      ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLL: alu_result = op_a << op_b[4:0];
      ALU_SRL: alu_result = op_a >> op_b[4:0];
      default: alu_result = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_mem_valid <= 1'b0;
      o_mem_we    <= 1'b0;
      o_mem_load  <= 1'b0;
      o_mem_store <= 1'b0;
    end else begin
      o_mem_valid <= i_ex_valid;
      o_mem_we    <= i_ex_valid && i_ex_we;
      o_mem_load  <= i_ex_valid && i_ex_load;
      o_mem_store <= i_ex_valid && i_ex_store;
    end
  end

  always_ff @(posedge i_clk) begin
    o_mem_rd         <= i_ex_rd;
    o_mem_result     <= alu_result;
    o_mem_store_data <= rs2_fwd;
  end

endmodule

// ==== logic/fetch_buffer.sv ====
`timescale 1ns/1ps

module fetch_buffer (
  input  logic            i_clk,
  input  logic            i_reset,
  input  logic            i_inst_valid,
  input  core_pkg::inst_t i_inst,
  input  logic            i_stall,
  output logic            o_inst_valid,
  output core_pkg::inst_t o_inst,
  output logic            o_credit
);

  import core_pkg::*;

  inst_t                              entries [FETCH_DEPTH];
  logic [$clog2(FETCH_DEPTH)-1:0]     head;
  logic [$clog2(FETCH_DEPTH)-1:0]     tail;
  logic [$clog2(FETCH_DEPTH+1)-1:0]   count;
  logic                               pop;

  // Head is presented as soon as the queue holds anything
  assign o_inst_valid = (count != '0);
  assign o_inst       = entries[head];
  assign pop          = o_inst_valid && !i_stall;

  // One credit back per released instruction
  assign o_credit = pop;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (i_inst_valid) begin
        tail <= (tail == FETCH_DEPTH - 1) ? '0 : tail + 1'b1;
      end
      if (pop) begin
        head <= (head == FETCH_DEPTH - 1) ? '0 : head + 1'b1;
      end
      case ({i_inst_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Sender never exceeds its credits so the tail slot is always free
  always_ff @(posedge i_clk) begin
    if (i_inst_valid) begin
      entries[tail] <= i_inst;
    end
  end

endmodule

// ==== logic/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage (
  input  logic                i_clk,
  input  logic                i_reset,
  input  logic                i_mem_valid,
  input  logic                i_mem_we,
  input  logic                i_mem_load,
  input  logic                i_mem_store,
  input  core_pkg::reg_addr_t i_mem_rd,
  input  core_pkg::word_t     i_mem_result,
  input  core_pkg::word_t     i_mem_store_data,
  output logic                o_wb_valid,
  output logic                o_wb_we,
  output core_pkg::reg_addr_t o_wb_rd,
  output core_pkg::word_t     o_wb_data
);

  import core_pkg::*;

  word_t       dmem [DMEM_WORDS];
  dmem_index_t dmem_index;
  word_t       load_data;

  // Word index from address bits 7:2, upper bits ignored
  assign dmem_index = i_mem_result[$bits(dmem_index_t)+1:2];
  assign load_data  = dmem[dmem_index];

  // Memory starts from zero after reset
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (i_mem_valid && i_mem_store) begin
      dmem[dmem_index] <= i_mem_store_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_wb_valid <= 1'b0;
      o_wb_we    <= 1'b0;
    end else begin
      o_wb_valid <= i_mem_valid;
      o_wb_we    <= i_mem_valid && i_mem_we;
    end
  end

  // Writeback value
  always_ff @(posedge i_clk) begin
    o_wb_rd   <= i_mem_rd;
    o_wb_data <= i_mem_load ? load_data : i_mem_result;
  end

endmodule

// ==== logic/pipeline_core.sv ====
`timescale 1ns/1ps

module pipeline_core (
  input  logic                i_clk,
  input  logic                i_reset,
  input  logic                i_inst_valid,
  input  core_pkg::inst_t     i_inst,
  output logic                o_credit,
  output logic                o_retire_valid,
  output logic                o_retire_we,
  output core_pkg::reg_addr_t o_retire_rd,
  output core_pkg::word_t     o_retire_data
);

  import core_pkg::*;

  // Fetch buffer head
  logic      id_valid;
  inst_t     id_inst;
  logic      id_stall;

  // Decode to execute
  logic      ex_valid;
  logic      ex_we;
  logic      ex_load;
  logic      ex_store;
  logic      ex_use_imm;
  alu_op_t   ex_alu_op;
  reg_addr_t ex_rd;
  reg_addr_t ex_rs1_addr;
  reg_addr_t ex_rs2_addr;
  word_t     ex_rs1;
  word_t     ex_rs2;
  word_t     ex_imm;

  // Execute to memory
  logic      mem_valid;
  logic      mem_we;
  logic      mem_load;
  logic      mem_store;
  reg_addr_t mem_rd;
  word_t     mem_result;
  word_t     mem_store_data;

  // Writeback, also the retire port
  logic      wb_valid;
  logic      wb_we;
  reg_addr_t wb_rd;
  word_t     wb_data;

  assign o_retire_valid = wb_valid;
  assign o_retire_we    = wb_we;
  assign o_retire_rd    = wb_rd;
  assign o_retire_data  = wb_data;

  fetch_buffer fetch_buffer_i (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .i_stall      (id_stall),
    .o_inst_valid (id_valid),
    .o_inst       (id_inst),
    .o_credit     (o_credit)
  );

  decode_stage decode_stage_i (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_inst_valid  (id_valid),
    .i_inst        (id_inst),
    .i_wb_we       (wb_we),
    .i_wb_rd       (wb_rd),
    .i_wb_data     (wb_data),
    .o_stall       (id_stall),
    .o_ex_valid    (ex_valid),
    .o_ex_we       (ex_we),
    .o_ex_load     (ex_load),
    .o_ex_store    (ex_store),
    .o_ex_use_imm  (ex_use_imm),
    .o_ex_alu_op   (ex_alu_op),
    .o_ex_rd       (ex_rd),
    .o_ex_rs1_addr (ex_rs1_addr),
    .o_ex_rs2_addr (ex_rs2_addr),
    .o_ex_rs1      (ex_rs1),
    .o_ex_rs2      (ex_rs2),
    .o_ex_imm      (ex_imm)
  );

  execute_stage execute_stage_i (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_ex_valid       (ex_valid),
    .i_ex_we          (ex_we),
    .i_ex_load        (ex_load),
    .i_ex_store       (ex_store),
    .i_ex_use_imm     (ex_use_imm),
    .i_ex_alu_op      (ex_alu_op),
    .i_ex_rd          (ex_rd),
    .i_ex_rs1_addr    (ex_rs1_addr),
    .i_ex_rs2_addr    (ex_rs2_addr),
    .i_ex_rs1         (ex_rs1),
    .i_ex_rs2         (ex_rs2),
    .i_ex_imm         (ex_imm),
    .i_wb_valid       (wb_valid),
    .i_wb_we          (wb_we),
    .i_wb_rd          (wb_rd),
    .i_wb_data        (wb_data),
    .o_mem_valid      (mem_valid),
    .o_mem_we         (mem_we),
    .o_mem_load       (mem_load),
    .o_mem_store      (mem_store),
    .o_mem_rd         (mem_rd),
    .o_mem_result     (mem_result),
    .o_mem_store_data (mem_store_data)
  );

  memory_stage memory_stage_i (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_mem_valid      (mem_valid),
    .i_mem_we         (mem_we),
    .i_mem_load       (mem_load),
    .i_mem_store      (mem_store),
    .i_mem_rd         (mem_rd),
    .i_mem_result     (mem_result),
    .i_mem_store_data (mem_store_data),
    .o_wb_valid       (wb_valid),
    .o_wb_we          (wb_we),
    .o_wb_rd          (wb_rd),
    .o_wb_data        (wb_data)
  );

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/1ps

module register_file (
  input  logic                i_clk,
  input  logic                i_reset,
  input  logic                i_we,
  input  core_pkg::reg_addr_t i_waddr,
  input  core_pkg::word_t     i_wdata,
  input  core_pkg::reg_addr_t i_rs1_addr,
  input  core_pkg::reg_addr_t i_rs2_addr,
  output core_pkg::word_t     o_rs1,
  output core_pkg::word_t     o_rs2
);

  import core_pkg::*;

  word_t regs [1:31];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // x0 reads zero, a same-cycle write is passed straight through
  assign o_rs1 = (i_rs1_addr == '0) ? '0 :
                 (i_we && i_waddr == i_rs1_addr) ? i_wdata : regs[i_rs1_addr];
  assign o_rs2 = (i_rs2_addr == '0) ? '0 :
                 (i_we && i_waddr == i_rs2_addr) ? i_wdata : regs[i_rs2_addr];

endmodule

// ==== verif/pipeline_core_props.sv ====
`timescale 1ns/1ps

module pipeline_core_props (
  input logic                i_clk,
  input logic                i_reset,
  input logic                i_inst_valid,
  input logic                i_credit,
  input logic                i_retire_valid,
  input logic                i_retire_we,
  input core_pkg::reg_addr_t i_retire_rd
);

  import core_pkg::*;

  // Credits held by the sender, mirrored from the handshake
  int credits;

  // Failure count, read by the testbench when the run ends
  int unsigned failures = 0;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      credits <= FETCH_DEPTH;
    end else begin
      credits <= credits - int'(i_inst_valid) + int'(i_credit);
    end
  end

  assert property (@(posedge i_clk) disable iff (i_reset) i_inst_valid |-> credits > 0)
    else begin
      $error("instruction sent while the sender held no credit");
      failures++;
    end

  // First cycle out of reset
  assert property (@(posedge i_clk) $fell(i_reset) |-> !i_credit && !i_retire_valid)
    else begin
      $error("credit or retire active in the first cycle after reset");
      failures++;
    end

  assert property (@(posedge i_clk) disable iff (i_reset)
                   i_retire_valid && i_retire_we |-> i_retire_rd != '0)
    else begin
      $error("retire writes register x0");
      failures++;
    end

endmodule

bind pipeline_core pipeline_core_props pipeline_core_props_i (
  .i_clk          (i_clk),
  .i_reset        (i_reset),
  .i_inst_valid   (i_inst_valid),
  .i_credit       (o_credit),
  .i_retire_valid (o_retire_valid),
  .i_retire_we    (o_retire_we),
  .i_retire_rd    (o_retire_rd)
);

// ==== verif/tb_pipeline_core.sv ====
`timescale 1ns/1ps

module tb_pipeline_core;

  import core_pkg::*;

  localparam int NUM_INSTS      = 400;
  localparam int TIMEOUT_CYCLES = 2 * NUM_INSTS + 50;

  logic      i_clk;
  logic      i_reset;
  logic      i_inst_valid;
  inst_t     i_inst;
  logic      o_credit;
  logic      o_retire_valid;
  logic      o_retire_we;
  reg_addr_t o_retire_rd;
  word_t     o_retire_data;

  // Reference model state
  word_t       model_regs [32];
  word_t       model_mem [DMEM_WORDS];
  logic [37:0] expected_q [$];

  logic [31:0] rng_state = 32'd58076;
  int          credits = FETCH_DEPTH;
  int          sent = 0;
  int          retired = 0;
  int          credit_pulses = 0;
  int          cycle_count = 0;

  pipeline_core pipeline_core_i (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_inst_valid   (i_inst_valid),
    .i_inst         (i_inst),
    .o_credit       (o_credit),
    .o_retire_valid (o_retire_valid),
    .o_retire_we    (o_retire_we),
    .o_retire_rd    (o_retire_rd),
    .o_retire_data  (o_retire_data)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  // LCG, upper half is the better mixed part
  function automatic logic [15:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state[31:16];
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("test failed");
    $fatal(1, "run stopped on error");
  endtask

  task automatic compare_values(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      $display("test failed");
      $fatal(1, "run stopped on mismatch");
    end
  endtask

  // Op index 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 slt, 6 sll, 7 srl
  function automatic logic [2:0] funct3_of(input int op);
    case (op)
      2:       return 3'b111;
      3:       return 3'b110;
      4:       return 3'b100;
      5:       return 3'b010;
      6:       return 3'b001;
      7:       return 3'b101;
      default: return 3'b000;
    endcase
  endfunction

  function automatic word_t alu_model(input int op, input word_t a, input word_t b);
    case (op)
      1:       return a - b;
      2:       return a & b;
      3:       return a | b;
      4:       return a ^ b;
      5:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      6:       return a << b[4:0];
      7:       return a >> b[4:0];
      default: return a + b;
    endcase
  endfunction

  // Random instruction, executed on the model into the expected queue
  function automatic inst_t make_instruction();
    int          pick;
    int          op;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [11:0] imm;
    word_t       addr;
    word_t       result;
    dmem_index_t index;
    logic        writes;
    inst_t       inst;
    pick   = next_rand() % 9;
    op     = next_rand() % 8;
    rd     = reg_addr_t'(next_rand() % 8);
    rs1    = reg_addr_t'(next_rand() % 8);
    rs2    = reg_addr_t'(next_rand() % 8);
    imm    = 12'(next_rand());
    writes = 1'b1;
    result = '0;
    if (pick < 3) begin
      inst   = {(op == 1) ? 7'b0100000 : 7'b0000000, rs2, rs1, funct3_of(op), rd, OPC_OP};
      result = alu_model(op, model_regs[rs1], model_regs[rs2]);
    end else if (pick < 5) begin
      if (op == 1) begin
        op = 0;
      end
      if (op >= 6) begin
        imm[11:5] = '0;
      end
      inst   = {imm, rs1, funct3_of(op), rd, OPC_OP_IMM};
      result = alu_model(op, model_regs[rs1], {{20{imm[11]}}, imm});
    end else begin
      // Few word indices, many aliasing addresses
      if (next_rand() % 2 == 0) begin
        rs1 = '0;
      end
      imm[7:2] = 6'(next_rand() % 8);
      addr     = model_regs[rs1] + {{20{imm[11]}}, imm};
      index    = addr[7:2];
      if (pick < 7) begin
        inst   = {imm, rs1, 3'b010, rd, OPC_LOAD};
        result = model_mem[index];
      end else begin
        inst   = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
        model_mem[index] = model_regs[rs2];
        writes = 1'b0;
      end
    end
    if (rd == '0) begin
      writes = 1'b0;
    end
    if (writes) begin
      model_regs[rd] = result;
    end
    expected_q.push_back({writes, rd, result});
    return inst;
  endfunction

  initial begin
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      model_mem[i] = '0;
    end
    i_reset      = 1'b1;
    i_inst_valid = 1'b0;
    i_inst       = '0;
    repeat (4) @(posedge i_clk);
    i_reset <= 1'b0;
    while (sent < NUM_INSTS) begin
      @(posedge i_clk);
      if (credits > 0 && next_rand() % 8 != 0) begin
        i_inst       <= make_instruction();
        i_inst_valid <= 1'b1;
        credits--;
        sent++;
      end else begin
        i_inst_valid <= 1'b0;
      end
    end
    @(posedge i_clk);
    i_inst_valid <= 1'b0;
    while (retired < NUM_INSTS) begin
      @(posedge i_clk);
    end
    compare_values("credit pulses", NUM_INSTS, credit_pulses);
    if (pipeline_core_i.pipeline_core_props_i.failures == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("protocol assertions failed during the run");
      $display("test failed");
      $fatal(1, "run ended with assertion failures");
    end
  end

  // Outputs settle between edges
  always @(negedge i_clk) begin
    logic [37:0] entry;
    if (!i_reset) begin
      if (o_credit) begin
        credits++;
        credit_pulses++;
      end
      if (o_retire_valid) begin
        if (expected_q.size() == 0) begin
          report_failure("an instruction retired that was never sent");
        end else begin
          entry = expected_q.pop_front();
          compare_values($sformatf("retire %0d we", retired), entry[37], o_retire_we);
          if (entry[37]) begin
            compare_values($sformatf("retire %0d rd", retired), entry[36:32], o_retire_rd);
            compare_values($sformatf("retire %0d data", retired), entry[31:0], o_retire_data);
          end
          retired++;
        end
      end
    end
  end

  always @(posedge i_clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      report_failure($sformatf("timeout after %0d cycles, only %0d of %0d instructions retired",
                               cycle_count, retired, NUM_INSTS));
    end
  end

endmodule

// ==== verilog.f ====
logic/core_pkg.sv
logic/fetch_buffer.sv
logic/register_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/pipeline_core.sv
verif/pipeline_core_props.sv
verif/tb_pipeline_core.sv
